// File: flist.f
isaPkg.sv
pcPkg.sv
instrDecode.sv
branchResolve.sv
pcUpdate.sv
branchUnitTop.sv
tbBranchUnit.sv

// File: run.sh
#!/bin/sh
# Build and run the branch unit testbench with Verilator
# Exit status is 1 when the log holds the fail message

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f flist.f --top-module tbBranchUnit \
    -o simBranchUnit > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/simBranchUnit > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log

grep -q "Test failures found" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

// File: tbBranchUnit.sv
// --------------------------------------------------
// Self-checking testbench for the branch unit
// Expected results come from a reference model of the
// MIPS jump and branch rules
// A result is due 2 posedges after the drive edge
// and is sampled on the negedge that follows
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tbBranchUnit
    import isaPkg::*;
    import pcPkg::*;
;

    localparam int NUM_DIRECTED   = 50;
    localparam int NUM_RANDOM     = 120;
    localparam int NUM_INSTR      = NUM_DIRECTED + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = 16 + 2 * NUM_INSTR + 50;

    logic              clk = 1'b0;
    logic              arstN;
    logic              instrValid;
    instrWord          instr;
    logic [ADDR_W-1:0] pcIn;
    logic [ADDR_W-1:0] regA;
    logic [ADDR_W-1:0] regB;
    logic [ADDR_W-1:0] pcOut;
    logic              outValid;
    logic              taken;
    logic              linkWe;
    logic [4:0]        linkAddr;
    logic [ADDR_W-1:0] linkData;

    // Expected {nextPc, taken, linkWe, linkData} and due cycle per instruction
    logic [65:0]       expQ[$];
    int                dueQ[$];
    int                cycleCnt    = 0;
    logic [ADDR_W-1:0] lastPc      = RESET_PC;

    // Edge values for the signed compares
    logic [31:0] aVals[5] = '{32'd0, 32'd1, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h8000_0000};

    branchUnitTop dut0 (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .pcIn       (pcIn),
        .regA       (regA),
        .regB       (regB),
        .pcOut      (pcOut),
        .outValid   (outValid),
        .taken      (taken),
        .linkWe     (linkWe),
        .linkAddr   (linkAddr),
        .linkData   (linkData)
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk)
        cycleCnt <= cycleCnt + 1;

    // --------------------------------------------------
    // Reference model and reporting
    // --------------------------------------------------
    function automatic logic [65:0] refResolve(instrWord w, logic [31:0] pc,
                                               logic [31:0] a, logic [31:0] b);
        logic [31:0] branchDest;
        logic [31:0] jumpDest;
        logic [31:0] nextPc;
        logic [31:0] retAddr;
        logic        isTaken;
        logic        isJump;
        logic        isLink;
        branchDest = pc + {{14{w.iView.imm[15]}}, w.iView.imm, 2'b00};
        jumpDest   = {pc[31:28], w.jView.target, 2'b00};
        isTaken    = 1'b0;
        isJump     = 1'b0;
        isLink     = 1'b0;
        case (w.jView.op)
            OP_J:
            begin
                isTaken = 1'b1;
                isJump  = 1'b1;
            end
            OP_JAL:
            begin
                isTaken = 1'b1;
                isJump  = 1'b1;
                isLink  = 1'b1;
            end
            OP_BEQ:  isTaken = (a == b);
            OP_BNE:  isTaken = (a != b);
            OP_BLEZ: isTaken = ($signed(a) <= 0);
            OP_BGTZ: isTaken = ($signed(a) > 0);
            OP_REGIMM:
                case (w.iView.rt)
                    RT_BLTZ:   isTaken = ($signed(a) < 0);
                    RT_BGEZ:   isTaken = ($signed(a) >= 0);
                    RT_BLTZAL:
                    begin
                        isTaken = ($signed(a) < 0);
                        isLink  = 1'b1;
                    end
                    RT_BGEZAL:
                    begin
                        isTaken = ($signed(a) >= 0);
                        isLink  = 1'b1;
                    end
                    default:   isTaken = 1'b0;
                endcase
            default: isTaken = 1'b0;  // Not a control-flow word
        endcase
        if (!isTaken)
            nextPc = pc + PC_STEP;
        else if (isJump)
            nextPc = jumpDest;
        else
            nextPc = branchDest;
        retAddr = isLink ? pc + RET_OFFSET : 32'h0;
        return {nextPc, isTaken, isLink, retAddr};
    endfunction

    task automatic stopWithFailure(string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected)
        begin
            $display("ERROR: %s = 0x%h, expected 0x%h", name, got, expected);
            stopWithFailure($sformatf("Mismatch on %s at cycle %0d", name, cycleCnt));
        end
    endtask

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------

    // Kinds 0..9 are the control-flow forms and 10..12 non-branches
    function automatic instrWord encodeKind(int kind, logic [15:0] imm, logic [25:0] target);
        instrWord w;
        w.iView.op  = 6'd0;
        w.iView.rs  = 5'd4;
        w.iView.rt  = 5'd5;
        w.iView.imm = imm;
        case (kind)
            0:
            begin
                w.jView.op     = OP_J;
                w.jView.target = target;
            end
            1:
            begin
                w.jView.op     = OP_JAL;
                w.jView.target = target;
            end
            2:  w.iView.op = OP_BEQ;
            3:  w.iView.op = OP_BNE;
            4:  w.iView.op = OP_BLEZ;
            5:  w.iView.op = OP_BGTZ;
            6:
            begin
                w.iView.op = OP_REGIMM;
                w.iView.rt = RT_BLTZ;
            end
            7:
            begin
                w.iView.op = OP_REGIMM;
                w.iView.rt = RT_BGEZ;
            end
            8:
            begin
                w.iView.op = OP_REGIMM;
                w.iView.rt = RT_BLTZAL;
            end
            9:
            begin
                w.iView.op = OP_REGIMM;
                w.iView.rt = RT_BGEZAL;
            end
            10:
            begin
                w.iView.op = OP_REGIMM;
                w.iView.rt = 5'd2;  // Unused sub-code
            end
            11: w.iView.op = 6'(8 + $urandom() % 56);
            default: w.iView.op = 6'd0;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] randomPc();
        return $urandom() & 32'hFFFF_FFFC;
    endfunction

    task automatic issueInstr(instrWord w, logic [31:0] pc, logic [31:0] a, logic [31:0] b);
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= w;
        pcIn       <= pc;
        regA       <= a;
        regB       <= b;
        expQ.push_back(refResolve(w, pc, a, b));
        dueQ.push_back(cycleCnt + 3);  // Counter still lags this edge by one
    endtask

    task automatic idleCycles(int n);
        repeat (n)
        begin
            @(posedge clk);
            instrValid <= 1'b0;
            instr      <= $urandom();  // Junk must be ignored
            pcIn       <= $urandom();
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial
    begin
        int          i;
        int          kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        void'($urandom(32'hcbdb));
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pcIn       = '0;
        regA       = '0;
        regB       = '0;
        repeat (15) @(posedge clk);
        @(negedge clk);
        checkValue("pcOut", pcOut, RESET_PC);
        checkValue("outValid", 32'(outValid), 32'd0);
        checkValue("taken", 32'(taken), 32'd0);
        checkValue("linkWe", 32'(linkWe), 32'd0);
        @(posedge clk);
        arstN <= 1'b1;

        // J and JAL keep the upper PC nibble
        issueInstr(encodeKind(0, 16'h0, 26'h3FF_FFFF), 32'hBFC0_0100, $urandom(), $urandom());
        issueInstr(encodeKind(1, 16'h0, 26'h000_0001), 32'h0040_0020, $urandom(), $urandom());
        issueInstr(encodeKind(0, 16'h0, 26'h155_5555), 32'h7FFF_FFF8, $urandom(), $urandom());
        issueInstr(encodeKind(1, 16'h0, 26'h2AA_AAAA), 32'hBFC0_0000, $urandom(), $urandom());
        idleCycles(2);

        // BEQ and BNE with equal pairs and both offset signs
        for (i = 0; i < 16; i++)
        begin
            imm     = 16'($urandom());
            imm[15] = (i % 8 < 4);
            a       = $urandom();
            b       = (i % 4 < 2) ? a : $urandom();
            issueInstr(encodeKind(2 + i % 2, imm, 26'h0), randomPc(), a, b);
        end
        idleCycles(2);

        // Signed compares with and without link
        for (kind = 4; kind < 10; kind++)
            for (i = 0; i < 5; i++)
                issueInstr(encodeKind(kind, 16'($urandom()), 26'h0), randomPc(),
                           aVals[i], $urandom());
        idleCycles(2);

        // Random mix with idle gaps
        for (i = 0; i < NUM_RANDOM; i++)
        begin
            a = $urandom();
            b = ($urandom() % 2 == 0) ? a : $urandom();
            issueInstr(encodeKind(int'($urandom() % 13), 16'($urandom()), 26'($urandom())),
                       randomPc(), a, b);
            if ($urandom() % 4 == 0)
                idleCycles(1);
        end
        idleCycles(1);

        while (expQ.size() != 0)
            @(negedge clk);
        idleCycles(3);
        @(negedge clk);
        $display("All tests passed!");
        $finish;
    end

    // --------------------------------------------------
    // Checker sampling on the falling edge
    // --------------------------------------------------
    always @(negedge clk)
    begin
        logic [65:0] expVal;
        int          dueCycle;
        if (cycleCnt > TIMEOUT_CYCLES)
            stopWithFailure("Timeout: the run did not finish within the cycle limit");
        else if (arstN && outValid)
        begin
            if (expQ.size() == 0)
                stopWithFailure("outValid was high with no instruction in flight");
            else
            begin
                expVal   = expQ.pop_front();
                dueCycle = dueQ.pop_front();
                if (dueCycle != cycleCnt)
                    stopWithFailure($sformatf("Result came at cycle %0d, due at cycle %0d",
                                              cycleCnt, dueCycle));
                else
                begin
                    checkValue("pcOut", pcOut, expVal[65:34]);
                    checkValue("taken", 32'(taken), 32'(expVal[33]));
                    checkValue("linkWe", 32'(linkWe), 32'(expVal[32]));
                    if (expVal[32])
                    begin
                        checkValue("linkAddr", 32'(linkAddr), 32'(LINK_REG));
                        checkValue("linkData", linkData, expVal[31:0]);
                    end
                    lastPc = expVal[65:34];
                end
            end
        end
        else if (arstN)
        begin
            if (dueQ.size() > 0 && dueQ[0] <= cycleCnt)
                stopWithFailure("No result appeared 2 edges after an issued instruction");
            else
            begin
                checkValue("pcOut", pcOut, lastPc);  // Holds while idle
                checkValue("taken", 32'(taken), 32'd0);
                checkValue("linkWe", 32'(linkWe), 32'd0);
            end
        end
    end

endmodule

`default_nettype wire

// File: branchUnitTop.sv
// -------------------------------------------------
// Execute-stage control flow, top level
// Results appear 2 edges after instrValid
// One instruction per cycle at most, no stall input
// -------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module branchUnitTop
    import isaPkg::*;
    import pcPkg::*;
(
    input  wire logic              clk,
    input  wire logic              arstN,
    input  wire logic              instrValid,
    input  wire instrWord          instr,
    input  wire logic [ADDR_W-1:0] pcIn,
    input  wire logic [ADDR_W-1:0] regA,
    input  wire logic [ADDR_W-1:0] regB,
    output logic [ADDR_W-1:0]      pcOut,
    output logic                   outValid,
    output logic                   taken,
    output logic                   linkWe,
    output logic [4:0]             linkAddr,
    output logic [ADDR_W-1:0]      linkData
);

    // Execute-stage register outputs
    logic              exValid;
    logic [3:0]        exOp;
    logic              exEnable;
    logic              exLink;
    logic [ADDR_W-1:0] exPc;
    logic [ADDR_W-1:0] exA;
    logic [ADDR_W-1:0] exB;
    logic [ADDR_W-1:0] exOffset;

    // Resolved result
    logic              resTaken;
    logic [ADDR_W-1:0] resTarget;
    logic [ADDR_W-1:0] resRet;
    logic              resLink;

    instrDecode decode0 (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .pcIn       (pcIn),
        .regA       (regA),
        .regB       (regB),
        .exValid    (exValid),
        .exOp       (exOp),
        .exEnable   (exEnable),
        .exLink     (exLink),
        .exPc       (exPc),
        .exA        (exA),
        .exB        (exB),
        .exOffset   (exOffset)
    );

    branchResolve resolve0 (
        .exEnable  (exEnable),
        .exOp      (exOp),
        .exPc      (exPc),
        .exA       (exA),
        .exB       (exB),
        .exOffset  (exOffset),
        .exLink    (exLink),
        .resTaken  (resTaken),
        .resTarget (resTarget),
        .resRet    (resRet),
        .resLink   (resLink)
    );

    pcUpdate update0 (
        .clk       (clk),
        .arstN     (arstN),
        .exValid   (exValid),
        .resTaken  (resTaken),
        .resTarget (resTarget),
        .exPc      (exPc),
        .resRet    (resRet),
        .resLink   (resLink),
        .pcOut     (pcOut),
        .outValid  (outValid),
        .taken     (taken),
        .linkWe    (linkWe),
        .linkAddr  (linkAddr),
        .linkData  (linkData)
    );

endmodule

`default_nettype wire

// File: pcUpdate.sv
// -------------------------------------------------
// Fetch PC register and result outputs
// pcOut moves only on a valid result, else holds
// All outputs are strobes, no back-pressure
// linkAddr/linkData only meaningful with linkWe
// -------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pcUpdate
    import pcPkg::*;
(
    input  wire logic              clk,
    input  wire logic              arstN,
    input  wire logic              exValid,
    input  wire logic              resTaken,
    input  wire logic [ADDR_W-1:0] resTarget,
    input  wire logic [ADDR_W-1:0] exPc,
    input  wire logic [ADDR_W-1:0] resRet,
    input  wire logic              resLink,
    output logic [ADDR_W-1:0]      pcOut,
    output logic                   outValid,
    output logic                   taken,
    output logic                   linkWe,
    output logic [4:0]             linkAddr,
    output logic [ADDR_W-1:0]      linkData
);

    logic [ADDR_W-1:0] nextPc;

    // Redirect or fall through to the next word
    assign nextPc = resTaken ? resTarget : exPc + PC_STEP;

    // -------------------------------------------------
    // Fetch PC and strobes
    // -------------------------------------------------
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            pcOut    <= RESET_PC;
            outValid <= 1'b0;
            taken    <= 1'b0;
            linkWe   <= 1'b0;
        end
        else
        begin
            outValid <= exValid;
            taken    <= exValid && resTaken;
            linkWe   <= exValid && resLink;  // Taken or not
            if (exValid)
                pcOut <= nextPc;
        end
    end

    // Link write payload
    always_ff @(posedge clk)
    begin
        if (exValid && resLink)
        begin
            linkAddr <= LINK_REG;
            linkData <= resRet;
        end
    end

    linkOnlyWithResult: assert property (@(posedge clk) disable iff (!arstN)
        linkWe |-> outValid)
        else $error("linkWe without outValid");

endmodule

`default_nettype wire

// File: branchResolve.sv
// -------------------------------------------------
// Branch resolution, purely combinational
// Branch target is exPc plus offset*4, relative to
// the branch itself, not to the delay slot
// Jumps keep the upper 4 bits of exPc
// -------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module branchResolve
    import isaPkg::*;
    import pcPkg::*;
(
    input  wire logic              exEnable,
    input  wire logic [3:0]        exOp,
    input  wire logic [ADDR_W-1:0] exPc,
    input  wire logic [ADDR_W-1:0] exA,
    input  wire logic [ADDR_W-1:0] exB,
    input  wire logic [ADDR_W-1:0] exOffset,
    input  wire logic              exLink,
    output logic                   resTaken,
    output logic [ADDR_W-1:0]      resTarget,
    output logic [ADDR_W-1:0]      resRet,
    output logic                   resLink
);

    logic signed [ADDR_W-1:0] aSigned;
    logic [ADDR_W-1:0]        jumpTarget;
    logic [ADDR_W-1:0]        branchTarget;
    logic                     condMet;

    assign aSigned = exA;  // Compares against zero are signed

    // -------------------------------------------------
    // Candidate targets
    // -------------------------------------------------
    assign jumpTarget   = {exPc[ADDR_W-1:ADDR_W-4], exOffset[25:0], 2'b00};
    assign branchTarget = exPc + {exOffset[ADDR_W-3:0], 2'b00};

    // Branch condition per operation
    always_comb
    begin
        condMet = 1'b0;
        case (exOp)
            BR_J,
            BR_JAL:    condMet = 1'b1;
            BR_BEQ:    condMet = (exA == exB);
            BR_BNE:    condMet = (exA != exB);
            BR_BGEZ,
            BR_BGEZAL: condMet = (aSigned >= 0);
            BR_BGTZ:   condMet = (aSigned > 0);
            BR_BLEZ:   condMet = (aSigned <= 0);
            BR_BLTZ,
            BR_BLTZAL: condMet = (aSigned < 0);
            default:   condMet = 1'b0;
        endcase
    end

    // -------------------------------------------------
    // Outcome
    // -------------------------------------------------
    always_comb
    begin
        resTaken  = 1'b0;
        resTarget = exPc;  // Not taken stays at the branch PC
        if (exEnable && condMet)
        begin
            resTaken = 1'b1;
            if (exOp == BR_J || exOp == BR_JAL)
                resTarget = jumpTarget;
            else
                resTarget = branchTarget;
        end
    end

    assign resRet  = exPc + RET_OFFSET;  // Skip the delay slot
    assign resLink = exLink;

    // Taken must never come from a non-branch word
    always_comb
    begin
        takenNeedsEnable: assert final (!resTaken || exEnable)
            else $error("resTaken without exEnable");
    end

endmodule

`default_nettype wire

// File: instrDecode.sv
// -------------------------------------------------
// Decode and execute-stage register
// Operands arrive already read from the register file
// Unknown opcodes pass through with exEnable low
// Payload registers load on every edge, no stall
// -------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module instrDecode
    import isaPkg::*;
    import pcPkg::*;
(
    input  wire logic              clk,
    input  wire logic              arstN,
    input  wire logic              instrValid,
    input  wire instrWord          instr,
    input  wire logic [ADDR_W-1:0] pcIn,
    input  wire logic [ADDR_W-1:0] regA,
    input  wire logic [ADDR_W-1:0] regB,
    output logic                   exValid,
    output logic [3:0]             exOp,
    output logic                   exEnable,
    output logic                   exLink,
    output logic [ADDR_W-1:0]      exPc,
    output logic [ADDR_W-1:0]      exA,
    output logic [ADDR_W-1:0]      exB,
    output logic [ADDR_W-1:0]      exOffset
);

    logic [3:0]        decOp;
    logic              decEnable;
    logic              decLink;
    logic [ADDR_W-1:0] decOffset;

    // -------------------------------------------------
    // Opcode decode
    // -------------------------------------------------
    always_comb
    begin
        decOp     = BR_J;
        decEnable = 1'b1;
        decLink   = 1'b0;
        // Branch offset by default, sign extended
        decOffset = {{(ADDR_W-16){instr.iView.imm[15]}}, instr.iView.imm};

        case (instr.jView.op)
            OP_J:
            begin
                decOp     = BR_J;
                decOffset = {{(ADDR_W-26){1'b0}}, instr.jView.target};
            end
            OP_JAL:
            begin
                decOp     = BR_JAL;
                decLink   = 1'b1;
                decOffset = {{(ADDR_W-26){1'b0}}, instr.jView.target};
            end
            OP_BEQ:  decOp = BR_BEQ;
            OP_BNE:  decOp = BR_BNE;
            OP_BLEZ: decOp = BR_BLEZ;
            OP_BGTZ: decOp = BR_BGTZ;
            OP_REGIMM:
            begin
                case (instr.iView.rt)  // Sub-code picks the compare
                    RT_BLTZ:   decOp = BR_BLTZ;
                    RT_BGEZ:   decOp = BR_BGEZ;
                    RT_BLTZAL:
                    begin
                        decOp   = BR_BLTZAL;
                        decLink = 1'b1;
                    end
                    RT_BGEZAL:
                    begin
                        decOp   = BR_BGEZAL;
                        decLink = 1'b1;
                    end
                    default: decEnable = 1'b0;
                endcase
            end
            default: decEnable = 1'b0;  // Not a jump or branch
        endcase
    end

    // Control flags
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            exValid  <= 1'b0;
            exEnable <= 1'b0;
            exLink   <= 1'b0;
        end
        else
        begin
            exValid  <= instrValid;
            exEnable <= decEnable;
            exLink   <= decLink;
        end
    end

    // Payload
    always_ff @(posedge clk)
    begin
        exOp     <= decOp;
        exPc     <= pcIn;
        exA      <= regA;
        exB      <= regB;
        exOffset <= decOffset;
    end

    // A link write only ever comes from a recognized branch
    linkNeedsEnable: assert property (@(posedge clk) disable iff (!arstN)
        exLink |-> exEnable)
        else $error("exLink set for a non-branch opcode");

endmodule

`default_nettype wire

// File: pcPkg.sv
// -------------------------------------------------
// Program counter constants
// Fetch starts at the boot ROM vector after reset
// Return address skips the delay slot (PC+8)
// -------------------------------------------------
`default_nettype none

package pcPkg;

    localparam int ADDR_W = 32;  // Data and address width

    // Fetch PC out of reset
    localparam logic [ADDR_W-1:0] RESET_PC = 32'hBFC00000;

    // Register written by JAL, BGEZAL and BLTZAL
    localparam logic [4:0] LINK_REG = 5'd31;

    // Sequential fetch step, one word
    localparam logic [ADDR_W-1:0] PC_STEP = 32'd4;

    // Return address offset past the delay slot
    localparam logic [ADDR_W-1:0] RET_OFFSET = 32'd8;

endpackage

`default_nettype wire

// File: isaPkg.sv
// -------------------------------------------------
// MIPS-style jump and branch encodings
// Only the REGIMM, J, JAL and compare-branch major
// opcodes are covered; JR/JALR are not decoded
// Internal op codes are private to the execute stage
// -------------------------------------------------
`default_nettype none

package isaPkg;

    // -------------------------------------------------
    // Major opcodes, bits 31:26
    // -------------------------------------------------
    localparam logic [5:0] OP_REGIMM = 6'd1;  // Branch kind sits in rt
    localparam logic [5:0] OP_J      = 6'd2;
    localparam logic [5:0] OP_JAL    = 6'd3;
    localparam logic [5:0] OP_BEQ    = 6'd4;
    localparam logic [5:0] OP_BNE    = 6'd5;
    localparam logic [5:0] OP_BLEZ   = 6'd6;
    localparam logic [5:0] OP_BGTZ   = 6'd7;

    // REGIMM sub-codes in the rt field
    localparam logic [4:0] RT_BLTZ   = 5'd0;
    localparam logic [4:0] RT_BGEZ   = 5'd1;
    localparam logic [4:0] RT_BLTZAL = 5'd16;
    localparam logic [4:0] RT_BGEZAL = 5'd17;

    // -------------------------------------------------
    // Internal branch operations
    // -------------------------------------------------
    localparam logic [3:0] BR_J      = 4'd0;
    localparam logic [3:0] BR_JAL    = 4'd1;
    localparam logic [3:0] BR_BEQ    = 4'd2;
    localparam logic [3:0] BR_BNE    = 4'd3;
    localparam logic [3:0] BR_BGEZ   = 4'd4;
    localparam logic [3:0] BR_BGEZAL = 4'd5;
    localparam logic [3:0] BR_BGTZ   = 4'd6;
    localparam logic [3:0] BR_BLEZ   = 4'd7;
    localparam logic [3:0] BR_BLTZ   = 4'd8;
    localparam logic [3:0] BR_BLTZAL = 4'd9;

    // -------------------------------------------------
    // Instruction word views
    // -------------------------------------------------

    // Immediate form, used by BEQ/BNE, compares and REGIMM
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;   // Second source or REGIMM sub-code
        logic [15:0] imm;  // Word offset, signed
    } iFormat;

    // Jump form, used by J and JAL
    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;  // Word index inside the 256 MB region
    } jFormat;

    // Same 32 bits, decoded either way
    typedef union packed {
        iFormat iView;
        jFormat jView;
    } instrWord;

endpackage

`default_nettype wire
